//--- design/cam_power_seq.sv
//--------------------
// sensor reset held >= CAM_RESET_CYCLES clocks after reset release
// pwdn follows the system reset directly
//--------------------
`timescale 1ns/1ps

module cam_power_seq #(
	parameter int unsigned CAM_RESET_CYCLES = video_hdr_pkg::CAM_RESET_CYCLES_DEF
) (
	input  logic sys_clk_b,
	input  logic reset_n_b,
	output logic cam_pwdn_o,
	output logic cam_resetb_o
);

	localparam int CNT_W = (CAM_RESET_CYCLES < 1) ? 1 : $clog2(CAM_RESET_CYCLES + 1);

	logic             start_q;
	logic             run_q;
	logic [CNT_W-1:0] cnt_q;
	logic             stop;

	assign stop = (cnt_q == CNT_W'(CAM_RESET_CYCLES));

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			start_q      <= 1'b0;
			run_q        <= 1'b0;
			cnt_q        <= '0;
			cam_resetb_o <= 1'b0;
		end
		else
		begin
			start_q <= 1'b1;
			if (stop)
				run_q <= 1'b0;
			else if (!start_q)
				run_q <= 1'b1;	// first clock out of reset
			if (run_q && !stop)
				cnt_q <= cnt_q + 1'b1;
			if (stop)
				cam_resetb_o <= 1'b1;	// sticky until next reset
		end
	end

	assign cam_pwdn_o = ~reset_n_b;

	// sensor must not see a second reset pulse without a system reset
	a_resetb_sticky: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		cam_resetb_o |=> cam_resetb_o
	);

endmodule

//--- design/hdr_merge.sv
//--------------------
// HDR sample is the plain sum of both cameras, one cycle latency
//--------------------
`timescale 1ns/1ps

module hdr_merge (
	input  logic                            sys_clk_b,
	input  logic                            reset_n_b,
	input  logic [video_hdr_pkg::CAM_W-1:0] cam0_i,
	input  logic [video_hdr_pkg::CAM_W-1:0] cam1_i,
	input  logic                            valid_i,
	input  logic                            sop_i,
	input  logic                            eop_i,
	video_stream_if.src                     hdr
);

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
			hdr.valid <= 1'b0;
		else
			hdr.valid <= valid_i;
	end

	// payload, qualified by hdr.valid
	always_ff @(posedge sys_clk_b)
	begin
		hdr.data <= video_hdr_pkg::HDR_W'(cam0_i) + video_hdr_pkg::HDR_W'(cam1_i);
		hdr.sop  <= sop_i;
		hdr.eop  <= eop_i;
	end

	// every hdr beat carries a known sample and known flags
	a_hdr_known: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		hdr.valid |-> !$isunknown({hdr.data, hdr.sop, hdr.eop})
	);

endmodule

//--- design/mode_sync.sv
//--------------------
// mode switches are async, loaded only while synced vsync is high
//--------------------
`timescale 1ns/1ps

module mode_sync (
	input  logic                             sys_clk_b,
	input  logic                             reset_n_b,
	input  logic [video_hdr_pkg::MODE_W-1:0] switches_i,
	input  logic                             vsync_i,
	output logic [video_hdr_pkg::MODE_W-1:0] mode_o
);

	logic [1:0]                       vs_sync;
	logic [video_hdr_pkg::MODE_W-1:0] sw_meta;
	logic [video_hdr_pkg::MODE_W-1:0] sw_sync;

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
		begin
			vs_sync <= '0;
			sw_meta <= '0;
			sw_sync <= '0;
			mode_o  <= '0;	// camera 0
		end
		else
		begin
			vs_sync <= {vs_sync[0], vsync_i};
			sw_meta <= switches_i;
			sw_sync <= sw_meta;
			// frame blanking only, never mid-frame
			if (vs_sync[1])
				mode_o <= sw_sync;
		end
	end

endmodule

//--- design/pixel_select.sv
//--------------------
// only mode bits 1:0 decoded, 00 acts as camera 0
// HDR path keeps sum bits 8:1, the mean of both cameras
//--------------------
`timescale 1ns/1ps

module pixel_select (
	input  logic                             sys_clk_b,
	input  logic                             reset_n_b,
	input  logic [video_hdr_pkg::MODE_W-1:0] mode_i,
	input  logic [video_hdr_pkg::CAM_W-1:0]  cam0_i,
	input  logic [video_hdr_pkg::CAM_W-1:0]  cam1_i,
	input  logic                             valid_i,
	input  logic                             sop_i,
	input  logic                             eop_i,
	video_stream_if.snk                      hdr,
	output logic [video_hdr_pkg::OUT_W-1:0]  pix_o,
	output logic                             pix_valid_o,
	output logic                             pix_sop_o,
	output logic                             pix_eop_o
);

	logic [video_hdr_pkg::OUT_W-1:0] sel_pix;
	logic                            sel_valid;
	logic                            sel_sop;
	logic                            sel_eop;

	always_comb
	begin
		case (mode_i[1:0])
			video_hdr_pkg::SRC_CAM1:
			begin
				sel_pix   = cam1_i;
				sel_valid = valid_i;
				sel_sop   = sop_i;
				sel_eop   = eop_i;
			end
			video_hdr_pkg::SRC_HDR:
			begin
				sel_pix   = hdr.data[video_hdr_pkg::OUT_W:1];	// sum / 2
				sel_valid = hdr.valid;
				sel_sop   = hdr.sop;
				sel_eop   = hdr.eop;
			end
			default:	// SRC_CAM0 and 00
			begin
				sel_pix   = cam0_i;
				sel_valid = valid_i;
				sel_sop   = sop_i;
				sel_eop   = eop_i;
			end
		endcase
	end

	always_ff @(posedge sys_clk_b or negedge reset_n_b)
	begin
		if (!reset_n_b)
			pix_valid_o <= 1'b0;
		else
			pix_valid_o <= sel_valid;
	end

	always_ff @(posedge sys_clk_b)
	begin
		pix_o     <= sel_pix;
		pix_sop_o <= sel_sop;
		pix_eop_o <= sel_eop;
	end

	// catches an unwritten HDR register or a camera input left floating
	a_pix_known: assert property (
		@(posedge sys_clk_b) disable iff (!reset_n_b)
		pix_valid_o |-> !$isunknown(pix_o)
	);

endmodule

//--- design/video_hdr_pkg.sv
//--------------------
// widths and mode codes for the sys_clk_b video path
// mode switch bits 3:2 carry no meaning here
//--------------------
package video_hdr_pkg;

	localparam int CAM_W  = 8;	// one camera pixel
	localparam int HDR_W  = 10;	// cam0 + cam1, no overflow
	localparam int OUT_W  = 8;
	localparam int MODE_W = 4;

	// switch bits 1:0, code 00 falls back to camera 0
	localparam logic [1:0] SRC_CAM0 = 2'b01;
	localparam logic [1:0] SRC_CAM1 = 2'b10;
	localparam logic [1:0] SRC_HDR  = 2'b11;

	// sensor reset hold in sys_clk_b cycles
	localparam logic [31:0] CAM_RESET_CYCLES_DEF = 32'd2500;

endpackage

//--- design/video_hdr_top.sv
//--------------------
// camera modes 1 cycle latency, HDR mode 2 cycles
// output stream cannot stall
//--------------------
`timescale 1ns/1ps

module video_hdr_top #(
	parameter int unsigned CAM_RESET_CYCLES = video_hdr_pkg::CAM_RESET_CYCLES_DEF
) (
	input  logic                             sys_clk_b,
	input  logic                             reset_n_b,
	input  logic [video_hdr_pkg::MODE_W-1:0] switches_i,
	input  logic                             vsync_i,
	input  logic [video_hdr_pkg::CAM_W-1:0]  cam0_data_i,
	input  logic [video_hdr_pkg::CAM_W-1:0]  cam1_data_i,
	input  logic                             raw_valid_i,
	input  logic                             raw_sop_i,
	input  logic                             raw_eop_i,
	output logic [video_hdr_pkg::OUT_W-1:0]  pix_o,
	output logic                             pix_valid_o,
	output logic                             pix_sop_o,
	output logic                             pix_eop_o,
	output logic                             cam_pwdn_o,
	output logic                             cam_resetb_o
);

	logic [video_hdr_pkg::MODE_W-1:0] mode;

	video_stream_if #(
		.DATA_W (video_hdr_pkg::HDR_W)
	) hdr_stream ();

	cam_power_seq #(
		.CAM_RESET_CYCLES (CAM_RESET_CYCLES)
	) u_cam_power_seq (
		.sys_clk_b    (sys_clk_b),
		.reset_n_b    (reset_n_b),
		.cam_pwdn_o   (cam_pwdn_o),
		.cam_resetb_o (cam_resetb_o)	// shared by both sensors
	);

	mode_sync u_mode_sync (
		.sys_clk_b  (sys_clk_b),
		.reset_n_b  (reset_n_b),
		.switches_i (switches_i),
		.vsync_i    (vsync_i),
		.mode_o     (mode)
	);

	hdr_merge u_hdr_merge (
		.sys_clk_b (sys_clk_b),
		.reset_n_b (reset_n_b),
		.cam0_i    (cam0_data_i),
		.cam1_i    (cam1_data_i),
		.valid_i   (raw_valid_i),
		.sop_i     (raw_sop_i),
		.eop_i     (raw_eop_i),
		.hdr       (hdr_stream.src)
	);

	// raw flags go to both merge and select
	pixel_select u_pixel_select (
		.sys_clk_b   (sys_clk_b),
		.reset_n_b   (reset_n_b),
		.mode_i      (mode),
		.cam0_i      (cam0_data_i),
		.cam1_i      (cam1_data_i),
		.valid_i     (raw_valid_i),
		.sop_i       (raw_sop_i),
		.eop_i       (raw_eop_i),
		.hdr         (hdr_stream.snk),
		.pix_o       (pix_o),
		.pix_valid_o (pix_valid_o),
		.pix_sop_o   (pix_sop_o),
		.pix_eop_o   (pix_eop_o)
	);

endmodule

//--- design/video_stream_if.sv
//--------------------
// valid/sop/eop stream, no ready and no back-pressure
// data, sop, eop are only meaningful while valid is high
//--------------------
`timescale 1ns/1ps

interface video_stream_if #(
	parameter int DATA_W = 8
);

	logic              valid;
	logic [DATA_W-1:0] data;
	logic              sop;	// first pixel of frame
	logic              eop;	// last pixel of frame

	modport src (
		output valid,
		output data,
		output sop,
		output eop
	);

	modport snk (
		input valid,
		input data,
		input sop,
		input eop
	);

endinterface

//--- dv/video_hdr_tb_table.svh
//--------------------
// columns: no_vs, switches, cam0, cam1, sop, eop, rnd, expected pix
// rnd rows take both pixels from $urandom, expected then comes from the mode rule
//--------------------
localparam int NUM_ROWS = 16;

logic                             no_vs_t [NUM_ROWS];	// switches change with vsync low
logic [video_hdr_pkg::MODE_W-1:0] sw_t    [NUM_ROWS];
logic [video_hdr_pkg::CAM_W-1:0]  cam0_t  [NUM_ROWS];
logic [video_hdr_pkg::CAM_W-1:0]  cam1_t  [NUM_ROWS];
logic                             sop_t   [NUM_ROWS];
logic                             eop_t   [NUM_ROWS];
logic                             rnd_t   [NUM_ROWS];
logic [video_hdr_pkg::CAM_W-1:0]  exp_t   [NUM_ROWS];

task automatic set_row(
	input int                               idx,
	input logic                             nv,
	input logic [video_hdr_pkg::MODE_W-1:0] sw,
	input logic [video_hdr_pkg::CAM_W-1:0]  c0,
	input logic [video_hdr_pkg::CAM_W-1:0]  c1,
	input logic                             sop,
	input logic                             eop,
	input logic                             rnd,
	input logic [video_hdr_pkg::CAM_W-1:0]  exp
);
	no_vs_t[idx] = nv;
	sw_t[idx]    = sw;
	cam0_t[idx]  = c0;
	cam1_t[idx]  = c1;
	sop_t[idx]   = sop;
	eop_t[idx]   = eop;
	rnd_t[idx]   = rnd;
	exp_t[idx]   = exp;
endtask

task automatic fill_table();
	set_row(0,  1'b0, 4'b0001, 8'h3c, 8'hc5, 1'b1, 1'b0, 1'b0, 8'h3c);
	set_row(1,  1'b0, 4'b0010, 8'h12, 8'hab, 1'b0, 1'b0, 1'b0, 8'hab);
	set_row(2,  1'b0, 4'b0011, 8'hff, 8'hff, 1'b0, 1'b0, 1'b0, 8'hff);	// no overflow
	set_row(3,  1'b0, 4'b0011, 8'h01, 8'h02, 1'b1, 1'b1, 1'b0, 8'h01);	// rounds down
	set_row(4,  1'b0, 4'b0000, 8'h5a, 8'ha5, 1'b0, 1'b0, 1'b0, 8'h5a);
	// source stays camera 0 until the next vsync
	set_row(5,  1'b1, 4'b0010, 8'h77, 8'h88, 1'b0, 1'b0, 1'b0, 8'h77);
	set_row(6,  1'b0, 4'b0010, 8'h77, 8'h88, 1'b0, 1'b0, 1'b0, 8'h88);
	set_row(7,  1'b1, 4'b0011, 8'h10, 8'h20, 1'b0, 1'b1, 1'b0, 8'h20);
	set_row(8,  1'b0, 4'b0011, 8'h80, 8'h7f, 1'b1, 1'b0, 1'b0, 8'h7f);
	set_row(9,  1'b1, 4'b0001, 8'hfe, 8'h03, 1'b0, 1'b0, 1'b0, 8'h80);	// still HDR
	// bits 3:2 carry no meaning
	set_row(10, 1'b0, 4'b1101, 8'h00, 8'h00, 1'b1, 1'b0, 1'b1, 8'h00);
	set_row(11, 1'b0, 4'b0110, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 8'h00);
	set_row(12, 1'b0, 4'b1111, 8'h00, 8'h00, 1'b0, 1'b1, 1'b1, 8'h00);
	set_row(13, 1'b0, 4'b0011, 8'h00, 8'h00, 1'b1, 1'b1, 1'b1, 8'h00);
	set_row(14, 1'b0, 4'b1000, 8'h00, 8'h00, 1'b0, 1'b0, 1'b1, 8'h00);
	set_row(15, 1'b0, 4'b0001, 8'hc3, 8'h3c, 1'b0, 1'b1, 1'b0, 8'hc3);
endtask

//--- dv/video_hdr_tb.sv
//--------------------
// one isolated beat per table row, no real frame timing
// CAM_RESET_CYCLES cut to 20 so the sensor reset release is seen quickly
//--------------------
`timescale 1ns/1ps

module video_hdr_tb;

	localparam int unsigned CAM_RESET_CYCLES = 20;

	logic                             sys_clk_b;
	logic                             reset_n_b;
	logic [video_hdr_pkg::MODE_W-1:0] switches;
	logic                             vsync;
	logic [video_hdr_pkg::CAM_W-1:0]  cam0_data;
	logic [video_hdr_pkg::CAM_W-1:0]  cam1_data;
	logic                             raw_valid;
	logic                             raw_sop;
	logic                             raw_eop;
	logic [video_hdr_pkg::OUT_W-1:0]  pix;
	logic                             pix_valid;
	logic                             pix_sop;
	logic                             pix_eop;
	logic                             cam_pwdn;
	logic                             cam_resetb;

	`include "video_hdr_tb_table.svh"

	int unsigned                      seed;
	int unsigned                      rword;
	int                               errors;
	int                               checks;
	int                               r;
	logic                             resetb_done;
	logic [video_hdr_pkg::MODE_W-1:0] live_mode;	// switches last loaded under vsync
	logic [video_hdr_pkg::CAM_W-1:0]  c0;
	logic [video_hdr_pkg::CAM_W-1:0]  c1;
	logic [video_hdr_pkg::CAM_W-1:0]  exp_pix;
	logic                             hdr_path;

	video_hdr_top #(
		.CAM_RESET_CYCLES (CAM_RESET_CYCLES)
	) u_dut (
		.sys_clk_b    (sys_clk_b),
		.reset_n_b    (reset_n_b),
		.switches_i   (switches),
		.vsync_i      (vsync),
		.cam0_data_i  (cam0_data),
		.cam1_data_i  (cam1_data),
		.raw_valid_i  (raw_valid),
		.raw_sop_i    (raw_sop),
		.raw_eop_i    (raw_eop),
		.pix_o        (pix),
		.pix_valid_o  (pix_valid),
		.pix_sop_o    (pix_sop),
		.pix_eop_o    (pix_eop),
		.cam_pwdn_o   (cam_pwdn),
		.cam_resetb_o (cam_resetb)
	);

	initial
	begin
		sys_clk_b = 1'b0;
		forever #50 sys_clk_b = ~sys_clk_b;
	end

	initial
	begin
		repeat (NUM_ROWS * 12 + CAM_RESET_CYCLES + 20) @(posedge sys_clk_b);
		$display("timeout: the row sequence did not complete in the allowed cycles");
		$display("=== FAIL ===");
		$finish;
	end

	// sensor reset must never fall again once released
	always @(negedge sys_clk_b)
	begin
		if (resetb_done && cam_resetb !== 1'b1)
		begin
			errors = errors + 1;
			$display("[ERROR] cam_resetb_o: expected 0x1, got 0x%0h at %0t", cam_resetb, $time);
		end
	end

	// expected output pixel from mode bits 1:0
	function automatic logic [video_hdr_pkg::CAM_W-1:0] model_pix(
		input logic [video_hdr_pkg::MODE_W-1:0] mode,
		input logic [video_hdr_pkg::CAM_W-1:0]  a,
		input logic [video_hdr_pkg::CAM_W-1:0]  b
	);
		logic [video_hdr_pkg::CAM_W:0] sum;
		logic [video_hdr_pkg::CAM_W:0] half;
		sum  = {1'b0, a} + {1'b0, b};
		half = sum / 2;	// mean, rounded down
		case (mode[1:0])
			video_hdr_pkg::SRC_CAM0: model_pix = a;
			video_hdr_pkg::SRC_CAM1: model_pix = b;
			video_hdr_pkg::SRC_HDR:  model_pix = half[video_hdr_pkg::CAM_W-1:0];
			default:                 model_pix = a;	// 00 acts as camera 0
		endcase
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("[ERROR] %s: expected 0x%0h, got 0x%0h at %0t", name, exp, got, $time);
		end
	endtask

	// checks no beat comes out, returns on the next rising edge
	task automatic idle_cycle();
		@(negedge sys_clk_b);
		check_value("pix_valid_o", pix_valid, 1'b0);
		@(posedge sys_clk_b);
	endtask

	initial
	begin
		seed        = 32'h415fb612;
		rword       = $urandom(seed);
		errors      = 0;
		checks      = 0;
		r           = -1;
		resetb_done = 1'b0;
		live_mode   = '0;	// reset mode is camera 0
		reset_n_b   = 1'b0;
		switches    = '0;
		vsync       = 1'b0;
		cam0_data   = '0;
		cam1_data   = '0;
		raw_valid   = 1'b0;
		raw_sop     = 1'b0;
		raw_eop     = 1'b0;
		fill_table();

		@(negedge sys_clk_b);
		check_value("cam_pwdn_o", cam_pwdn, 1'b1);
		check_value("cam_resetb_o", cam_resetb, 1'b0);
		check_value("pix_valid_o", pix_valid, 1'b0);
		repeat (2) @(posedge sys_clk_b);
		reset_n_b <= 1'b1;

		for (int i = 1; i <= CAM_RESET_CYCLES + 3; i++)
		begin
			@(negedge sys_clk_b);
			check_value("cam_pwdn_o", cam_pwdn, 1'b0);
			check_value("pix_valid_o", pix_valid, 1'b0);
			if (i <= CAM_RESET_CYCLES)
				check_value("cam_resetb_o", cam_resetb, 1'b0);
			if (i == CAM_RESET_CYCLES + 3)
				check_value("cam_resetb_o", cam_resetb, 1'b1);
		end
		resetb_done = 1'b1;
		@(posedge sys_clk_b);

		for (r = 0; r < NUM_ROWS; r++)
		begin
			c0 = cam0_t[r];
			c1 = cam1_t[r];
			if (rnd_t[r])
			begin
				rword = $urandom();
				c0    = rword[7:0];
				c1    = rword[15:8];
			end
			switches <= sw_t[r];
			if (!no_vs_t[r])
			begin
				vsync <= 1'b1;
				repeat (4) idle_cycle();
				vsync <= 1'b0;
				repeat (2) idle_cycle();
				live_mode = sw_t[r];
			end
			else
				repeat (3) idle_cycle();	// synced switches settle, mode must hold
			hdr_path = (live_mode[1:0] == video_hdr_pkg::SRC_HDR);
			exp_pix  = rnd_t[r] ? model_pix(live_mode, c0, c1) : exp_t[r];

			raw_valid <= 1'b1;
			cam0_data <= c0;
			cam1_data <= c1;
			raw_sop   <= sop_t[r];
			raw_eop   <= eop_t[r];
			@(negedge sys_clk_b);
			check_value("pix_valid_o", pix_valid, 1'b0);
			@(posedge sys_clk_b);
			raw_valid <= 1'b0;
			raw_sop   <= 1'b0;
			raw_eop   <= 1'b0;
			if (hdr_path)
				idle_cycle();	// extra merge stage
			@(negedge sys_clk_b);
			check_value("pix_valid_o", pix_valid, 1'b1);
			check_value("pix_o", pix, exp_pix);
			check_value("pix_sop_o", pix_sop, sop_t[r]);
			check_value("pix_eop_o", pix_eop, eop_t[r]);
			@(posedge sys_clk_b);
		end

		repeat (2) idle_cycle();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

//--- video_hdr_top.f
+incdir+dv
design/video_hdr_pkg.sv
design/video_stream_if.sv
design/cam_power_seq.sv
design/mode_sync.sv
design/hdr_merge.sv
design/pixel_select.sv
design/video_hdr_top.sv
dv/video_hdr_tb.sv
